//--- flist.f
+incdir+tests
hw/ofdm_layout_pkg.sv
hw/ofdm_mod_pkg.sv
hw/byte_collector.sv
hw/constellation_mapper.sv
hw/symbol_buffer.sv
hw/subcarrier_sequencer.sv
hw/ofdm_payload_gen.sv
tests/ofdm_payload_gen_tb.sv

//--- Bender.yml
package:
  name: ofdm_payload_gen

sources:
  - hw/ofdm_layout_pkg.sv
  - hw/ofdm_mod_pkg.sv
  - hw/byte_collector.sv
  - hw/constellation_mapper.sv
  - hw/symbol_buffer.sv
  - hw/subcarrier_sequencer.sv
  - hw/ofdm_payload_gen.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/ofdm_payload_gen_tb.sv

//--- tests/ofdm_ref_model.svh
`ifndef OFDM_REF_MODEL_SVH
`define OFDM_REF_MODEL_SVH

////////////////////////////////////////
// symbol layout
////////////////////////////////////////

// largest payload of one symbol is qam16 at 4 bytes per group
localparam int REF_MAX_BYTES = 96;

function automatic bin_kind_e classify_bin(input int n);
    if (n == 0 || (n >= 101 && n <= 155))
        return BIN_NULL;
    if (n == 13 || n == 38 || n == 63 || n == 88)
        return BIN_PILOT_POS;
    if (n == 168 || n == 193 || n == 218 || n == 243)
        return BIN_PILOT_NEG;
    return BIN_DATA;
endfunction

// data symbols are used in bin order
function automatic int data_index_of(input int n);
    int count;
    count = 0;
    for (int b = 0; b < n; b++)
    begin
        if (classify_bin(b) == BIN_DATA)
            count++;
    end
    return count;
endfunction

////////////////////////////////////////
// constellation
////////////////////////////////////////

function automatic int bits_per_subcarrier(input mod_e mode);
    if (mode == MOD_QAM16)
        return 4;
    if (mode == MOD_QPSK)
        return 2;
    return 1;
endfunction

function automatic int gray_to_level(input logic b_lo, input logic b_hi);
    int steps;
    case ({b_hi, b_lo})
        2'b00:   steps = -3;
        2'b01:   steps = -1;
        2'b11:   steps = 1;
        default: steps = 3;
    endcase
    return steps * QAM16_UNIT;
endfunction

function automatic void expected_bin_iq(input int n, input mod_e mode,
                                        input logic [7:0] bytes [REF_MAX_BYTES],
                                        output int i_val, output int q_val);
    int pos;
    logic [3:0] field;
    i_val = 0;
    q_val = 0;
    case (classify_bin(n))
        BIN_PILOT_POS:
            i_val = PILOT_AMP;
        BIN_PILOT_NEG:
            i_val = -PILOT_AMP;
        BIN_DATA:
        begin
            // group g at byte g*B, subcarrier k at bit k*B, so index*B overall
            pos = data_index_of(n) * bits_per_subcarrier(mode);
            for (int b = 0; b < 4; b++)
                field[b] = (b < bits_per_subcarrier(mode)) ?
                           bytes[(pos + b) / 8][(pos + b) % 8] : 1'b0;
            if (mode == MOD_BPSK)
            begin
                i_val = field[0] ? BPSK_AMP : -BPSK_AMP;
            end
            else if (mode == MOD_QPSK)
            begin
                i_val = field[0] ? QPSK_AMP : -QPSK_AMP;
                q_val = field[1] ? QPSK_AMP : -QPSK_AMP;
            end
            else
            begin
                i_val = gray_to_level(field[0], field[1]);
                q_val = gray_to_level(field[2], field[3]);
            end
        end
        default:
            i_val = 0;
    endcase
endfunction

// 32 bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- tests/ofdm_payload_gen_tb.sv
module ofdm_payload_gen_tb
    import ofdm_layout_pkg::*;
    import ofdm_mod_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    `include "ofdm_ref_model.svh"

    localparam int          SAMPLE_W       = 16;
    localparam int          N_SYMBOLS      = 6;
    localparam int          EXTRA_BYTES    = 21;
    localparam int          TIMEOUT_CYCLES = N_SYMBOLS * (96 + 256) * 4 + 100;
    localparam logic [31:0] SEED           = 32'd4;

    logic                       clk;
    logic                       reset;
    logic                       in_valid_i;
    logic [7:0]                 in_data_i;
    mod_e                       modulation_i;
    logic                       ready_i;
    logic                       out_valid_o;
    logic signed [SAMPLE_W-1:0] out_i_o;
    logic signed [SAMPLE_W-1:0] out_q_o;
    logic                       out_last_o;

    // payload of the symbol in flight
    logic [7:0]  cur_bytes [REF_MAX_BYTES];
    mod_e        cur_mod;
    int          bin_count;
    int          symbols_done;
    logic        random_ready;
    logic [31:0] byte_lcg;
    logic [31:0] ready_lcg;

    ofdm_payload_gen #(
        .SAMPLE_W (SAMPLE_W)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .modulation_i (modulation_i),
        .ready_i      (ready_i),
        .out_valid_o  (out_valid_o),
        .out_i_o      (out_i_o),
        .out_q_o      (out_q_o),
        .out_last_o   (out_last_o)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH time %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    task automatic drive_byte(input logic [7:0] value);
        @(posedge clk);
        #1;
        in_valid_i   = 1'b1;
        in_data_i    = value;
        modulation_i = cur_mod;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
    endtask

    task automatic load_symbol(input mod_e mode);
        cur_mod = mode;
        for (int i = 0; i < REF_MAX_BYTES; i++)
        begin
            byte_lcg     = lcg_next(byte_lcg);
            cur_bytes[i] = (i < N_GROUPS * bits_per_subcarrier(mode)) ? byte_lcg[23:16] : 8'h00;
        end
    endtask

    task automatic send_symbol_bytes();
        for (int i = 0; i < N_GROUPS * bits_per_subcarrier(cur_mod); i++)
        begin
            byte_lcg = lcg_next(byte_lcg);
            // occasional gap between bytes
            if (byte_lcg[18:17] == 2'b00)
                idle_cycle();
            drive_byte(cur_bytes[i]);
        end
        idle_cycle();
    endtask

    task automatic send_extra_bytes(input int count);
        for (int i = 0; i < count; i++)
        begin
            byte_lcg = lcg_next(byte_lcg);
            drive_byte(byte_lcg[23:16]);
        end
        idle_cycle();
    endtask

    task automatic run_symbol(input mod_e mode);
        int target;
        target = symbols_done + 1;
        load_symbol(mode);
        send_symbol_bytes();
        wait (symbols_done == target);
    endtask

    // downstream ready goes random while random_ready is set
    initial
    begin
        ready_i   = 1'b1;
        ready_lcg = SEED;
        forever
        begin
            @(posedge clk);
            #1;
            ready_lcg = lcg_next(ready_lcg);
            ready_i   = random_ready ? ready_lcg[20] : 1'b1;
        end
    end

    ////////////////////////////////////////
    // output compare
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        int exp_i;
        int exp_q;
        if (!reset)
        begin
            if (out_valid_o)
            begin
                expected_bin_iq(bin_count, cur_mod, cur_bytes, exp_i, exp_q);
                check_value("out_i_o", exp_i, out_i_o);
                check_value("out_q_o", exp_q, out_q_o);
                check_value("out_last_o", (bin_count == N_FFT - 1), out_last_o);
                if (bin_count == N_FFT - 1)
                begin
                    bin_count = 0;
                    symbols_done++;
                end
                else
                    bin_count++;
            end
            else
                check_value("out_last_o", 0, out_last_o);
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("ERROR: the run timed out after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        reset        = 1'b1;
        in_valid_i   = 1'b0;
        in_data_i    = 8'h00;
        modulation_i = MOD_BPSK;
        cur_mod      = MOD_BPSK;
        random_ready = 1'b0;
        bin_count    = 0;
        symbols_done = 0;
        byte_lcg     = SEED;
        for (int i = 0; i < REF_MAX_BYTES; i++)
            cur_bytes[i] = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // nothing comes out without input
        repeat (50)
        begin
            @(negedge clk);
            check_value("out_valid_o", 0, out_valid_o);
            check_value("out_last_o", 0, out_last_o);
        end

        run_symbol(MOD_BPSK);
        run_symbol(MOD_QPSK);
        run_symbol(MOD_QAM16);

        // back-pressure during output
        random_ready = 1'b1;
        run_symbol(MOD_QAM16);
        random_ready = 1'b0;

        // bytes arriving while the buffer is full are dropped
        load_symbol(MOD_QPSK);
        send_symbol_bytes();
        wait (out_valid_o === 1'b1);
        send_extra_bytes(EXTRA_BYTES);
        wait (symbols_done == 5);
        run_symbol(MOD_BPSK);

        repeat (10) @(posedge clk);
        check_value("bin_count", 0, bin_count);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- hw/ofdm_payload_gen.sv
module ofdm_payload_gen
    import ofdm_layout_pkg::*;
    import ofdm_mod_pkg::*;
#(
    parameter int SAMPLE_W = 16
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid_i,
    input  logic [7:0]                 in_data_i,
    input  mod_e                       modulation_i,
    input  logic                       ready_i,
    output logic                       out_valid_o,
    output logic signed [SAMPLE_W-1:0] out_i_o,
    output logic signed [SAMPLE_W-1:0] out_q_o,
    output logic                       out_last_o
);

    logic                       group_valid;
    logic [GROUP_W-1:0]         group_word;
    mod_e                       group_mod;
    logic                       map_valid;
    logic signed [SAMPLE_W-1:0] sym_i [GROUP_SIZE];
    logic signed [SAMPLE_W-1:0] sym_q [GROUP_SIZE];
    logic                       buf_full;
    logic                       buf_release;
    logic [7:0]                 rd_index;
    logic signed [SAMPLE_W-1:0] rd_i;
    logic signed [SAMPLE_W-1:0] rd_q;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    byte_collector u_byte_collector (
        .clk           (clk),
        .reset         (reset),
        .in_valid_i    (in_valid_i),
        .in_data_i     (in_data_i),
        .modulation_i  (modulation_i),
        .buf_full_i    (buf_full),
        .group_valid_o (group_valid),
        .group_word_o  (group_word),
        .group_mod_o   (group_mod)
    );

    constellation_mapper #(
        .SAMPLE_W (SAMPLE_W)
    ) u_constellation_mapper (
        .clk           (clk),
        .reset         (reset),
        .group_valid_i (group_valid),
        .group_word_i  (group_word),
        .group_mod_i   (group_mod),
        .map_valid_o   (map_valid),
        .sym_i_o       (sym_i),
        .sym_q_o       (sym_q)
    );

    ////////////////////////////////////////
    // storage and output side
    ////////////////////////////////////////

    symbol_buffer #(
        .SAMPLE_W (SAMPLE_W)
    ) u_symbol_buffer (
        .clk         (clk),
        .reset       (reset),
        .map_valid_i (map_valid),
        .sym_i_i     (sym_i),
        .sym_q_i     (sym_q),
        .rd_index_i  (rd_index),
        .release_i   (buf_release),
        .rd_i_o      (rd_i),
        .rd_q_o      (rd_q),
        .full_o      (buf_full)
    );

    subcarrier_sequencer #(
        .SAMPLE_W (SAMPLE_W)
    ) u_subcarrier_sequencer (
        .clk         (clk),
        .reset       (reset),
        .buf_full_i  (buf_full),
        .ready_i     (ready_i),
        .rd_i_i      (rd_i),
        .rd_q_i      (rd_q),
        .rd_index_o  (rd_index),
        .release_o   (buf_release),
        .out_valid_o (out_valid_o),
        .out_i_o     (out_i_o),
        .out_q_o     (out_q_o),
        .out_last_o  (out_last_o)
    );

endmodule

//--- hw/subcarrier_sequencer.sv
module subcarrier_sequencer
    import ofdm_layout_pkg::*;
#(
    parameter int SAMPLE_W = 16
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       buf_full_i,
    input  logic                       ready_i,
    input  logic signed [SAMPLE_W-1:0] rd_i_i,
    input  logic signed [SAMPLE_W-1:0] rd_q_i,
    output logic [7:0]                 rd_index_o,
    output logic                       release_o,
    output logic                       out_valid_o,
    output logic signed [SAMPLE_W-1:0] out_i_o,
    output logic signed [SAMPLE_W-1:0] out_q_o,
    output logic                       out_last_o
);

    typedef enum logic {
        SEQ_IDLE,
        SEQ_SEND
    } seq_state_e;

    seq_state_e state;
    logic [7:0] bin_cnt;
    logic [7:0] data_idx;
    bin_kind_e  kind;
    logic       emit;
    logic       last_bin;

    assign kind       = bin_kind(bin_cnt);
    assign emit       = (state == SEQ_SEND) && buf_full_i && ready_i;
    assign last_bin   = (bin_cnt == 8'(N_FFT - 1));
    assign rd_index_o = data_idx;

    ////////////////////////////////////////
    // bin walk
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= SEQ_IDLE;
            bin_cnt     <= '0;
            data_idx    <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
            release_o   <= 1'b0;
        end
        else
        begin
            out_valid_o <= emit;
            out_last_o  <= emit && last_bin;
            release_o   <= emit && last_bin;
            case (state)
                SEQ_IDLE:
                begin
                    // full stays high one more cycle after a release
                    if (buf_full_i && !release_o)
                        state <= SEQ_SEND;
                end
                SEQ_SEND:
                begin
                    if (emit)
                    begin
                        bin_cnt <= bin_cnt + 1'b1;
                        if (kind == BIN_DATA)
                            data_idx <= data_idx + 1'b1;
                        if (last_bin)
                        begin
                            state    <= SEQ_IDLE;
                            data_idx <= '0;
                        end
                    end
                end
                default:
                    state <= SEQ_IDLE;
            endcase
        end
    end

    // output sample of the current bin
    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            case (kind)
                BIN_DATA:
                begin
                    out_i_o <= rd_i_i;
                    out_q_o <= rd_q_i;
                end
                BIN_PILOT_POS:
                begin
                    out_i_o <= SAMPLE_W'(PILOT_AMP);
                    out_q_o <= '0;
                end
                BIN_PILOT_NEG:
                begin
                    out_i_o <= SAMPLE_W'(-PILOT_AMP);
                    out_q_o <= '0;
                end
                default:
                begin
                    out_i_o <= '0;
                    out_q_o <= '0;
                end
            endcase
        end
    end

endmodule

//--- hw/symbol_buffer.sv
module symbol_buffer
    import ofdm_layout_pkg::*;
#(
    parameter int SAMPLE_W = 16
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       map_valid_i,
    input  logic signed [SAMPLE_W-1:0] sym_i_i [GROUP_SIZE],
    input  logic signed [SAMPLE_W-1:0] sym_q_i [GROUP_SIZE],
    input  logic [7:0]                 rd_index_i,
    input  logic                       release_i,
    output logic signed [SAMPLE_W-1:0] rd_i_o,
    output logic signed [SAMPLE_W-1:0] rd_q_o,
    output logic                       full_o
);

    logic signed [SAMPLE_W-1:0] mem_i [N_DATA];
    logic signed [SAMPLE_W-1:0] mem_q [N_DATA];

    logic [$clog2(N_GROUPS)-1:0] grp_cnt;
    logic                        wr_en;

    // a full buffer holds its contents until released
    assign wr_en = map_valid_i && !full_o;

    ////////////////////////////////////////
    // group counter and full flag
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || release_i)
        begin
            grp_cnt <= '0;
            full_o  <= 1'b0;
        end
        else if (wr_en)
        begin
            grp_cnt <= grp_cnt + 1'b1;
            if (int'(grp_cnt) == N_GROUPS - 1)
                full_o <= 1'b1;
        end
    end

    // eight entries per group at base group*8
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int k = 0; k < GROUP_SIZE; k++)
            begin
                mem_i[int'(grp_cnt) * GROUP_SIZE + k] <= sym_i_i[k];
                mem_q[int'(grp_cnt) * GROUP_SIZE + k] <= sym_q_i[k];
            end
        end
    end

    // asynchronous read for the sequencer
    assign rd_i_o = mem_i[rd_index_i];
    assign rd_q_o = mem_q[rd_index_i];

endmodule

//--- hw/constellation_mapper.sv
module constellation_mapper
    import ofdm_mod_pkg::*;
#(
    // at least 16 bits as the levels need 15 bits plus sign
    parameter int SAMPLE_W = 16
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       group_valid_i,
    input  logic [GROUP_W-1:0]         group_word_i,
    input  mod_e                       group_mod_i,
    output logic                       map_valid_o,
    output logic signed [SAMPLE_W-1:0] sym_i_o [GROUP_W/4],
    output logic signed [SAMPLE_W-1:0] sym_q_o [GROUP_W/4]
);

    // subcarriers per group word
    localparam int N_SC = GROUP_W / 4;

    logic signed [SAMPLE_W-1:0] lvl_i [N_SC];
    logic signed [SAMPLE_W-1:0] lvl_q [N_SC];

    ////////////////////////////////////////
    // field select and level lookup
    ////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < N_SC; k++)
        begin
            lvl_i[k] = '0;
            lvl_q[k] = '0;
            case (group_mod_i)
                MOD_BPSK:
                begin
                    lvl_i[k] = group_word_i[k] ? SAMPLE_W'(BPSK_AMP) : SAMPLE_W'(-BPSK_AMP);
                end
                MOD_QPSK:
                begin
                    // low bit on i, high bit on q
                    lvl_i[k] = group_word_i[2*k]   ? SAMPLE_W'(QPSK_AMP) : SAMPLE_W'(-QPSK_AMP);
                    lvl_q[k] = group_word_i[2*k+1] ? SAMPLE_W'(QPSK_AMP) : SAMPLE_W'(-QPSK_AMP);
                end
                MOD_QAM16:
                begin
                    lvl_i[k] = SAMPLE_W'(qam16_level(group_word_i[4*k +: 2]));
                    lvl_q[k] = SAMPLE_W'(qam16_level(group_word_i[4*k+2 +: 2]));
                end
                default:
                begin
                    // unknown code maps to silence
                    lvl_i[k] = '0;
                    lvl_q[k] = '0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            map_valid_o <= 1'b0;
        else
            map_valid_o <= group_valid_i;
    end

    always_ff @(posedge clk)
    begin
        for (int k = 0; k < N_SC; k++)
        begin
            sym_i_o[k] <= lvl_i[k];
            sym_q_o[k] <= lvl_q[k];
        end
    end

endmodule

//--- hw/byte_collector.sv
module byte_collector
    import ofdm_mod_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid_i,
    input  logic [7:0]         in_data_i,
    input  mod_e               modulation_i,
    input  logic               buf_full_i,
    output logic               group_valid_o,
    output logic [GROUP_W-1:0] group_word_o,
    output mod_e               group_mod_o
);

    localparam int N_LANES = GROUP_W / 8;

    logic [$clog2(N_LANES)-1:0] byte_cnt;
    mod_e                       mod_q;
    mod_e                       cur_mod;
    logic                       accept;
    logic                       last_byte;

    // first byte of a group picks the modulation for the whole group
    assign cur_mod   = (byte_cnt == '0) ? modulation_i : mod_q;
    assign accept    = in_valid_i && !buf_full_i;
    assign last_byte = (int'(byte_cnt) == bytes_per_group(cur_mod) - 1);

    assign group_mod_o = mod_q;

    ////////////////////////////////////////
    // lane counter and group strobe
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt      <= '0;
            mod_q         <= MOD_BPSK;
            group_valid_o <= 1'b0;
        end
        else
        begin
            group_valid_o <= accept && last_byte;
            if (accept)
            begin
                if (byte_cnt == '0)
                    mod_q <= modulation_i;
                if (last_byte)
                    byte_cnt <= '0;
                else
                    byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // byte lanes
    ////////////////////////////////////////

    // unused upper lanes keep stale bytes that the mapper ignores
    always_ff @(posedge clk)
    begin
        if (accept)
            group_word_o[8*byte_cnt +: 8] <= in_data_i;
    end

endmodule

//--- hw/ofdm_mod_pkg.sv
package ofdm_mod_pkg;

    ////////////////////////////////////////
    // modulation codes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        MOD_BPSK  = 3'd0,
        MOD_QPSK  = 3'd1,
        MOD_QAM16 = 3'd2
    } mod_e;

    // one group word holds the densest case of 8 subcarriers at 4 bits
    localparam int GROUP_W = 32;

    ////////////////////////////////////////
    // constellation levels
    ////////////////////////////////////////

    localparam int BPSK_AMP   = 8192;
    localparam int QPSK_AMP   = 5793;
    localparam int QAM16_UNIT = 2590;

    function automatic int bits_per_sc(input mod_e mode);
        int bits;
        case (mode)
            MOD_QPSK:  bits = 2;
            MOD_QAM16: bits = 4;
            default:   bits = 1;
        endcase
        return bits;
    endfunction

    // 8 subcarriers per group, so bytes per group equals bits per subcarrier
    function automatic int bytes_per_group(input mod_e mode);
        return bits_per_sc(mode);
    endfunction

    // gray coded axis level of a qam16 point
    function automatic int qam16_level(input logic [1:0] gray);
        int lvl;
        case (gray)
            2'b00:   lvl = -3 * QAM16_UNIT;
            2'b01:   lvl = -QAM16_UNIT;
            2'b11:   lvl = QAM16_UNIT;
            default: lvl = 3 * QAM16_UNIT;
        endcase
        return lvl;
    endfunction

endpackage

//--- hw/ofdm_layout_pkg.sv
package ofdm_layout_pkg;

    ////////////////////////////////////////
    // symbol geometry
    ////////////////////////////////////////

    localparam int N_FFT      = 256;
    localparam int N_DATA     = 192;
    localparam int GROUP_SIZE = 8;
    localparam int N_GROUPS   = N_DATA / GROUP_SIZE;

    // pilots carry a real value only
    localparam int PILOT_AMP  = 4096;

    typedef enum logic [1:0] {
        BIN_NULL,
        BIN_DATA,
        BIN_PILOT_POS,
        BIN_PILOT_NEG
    } bin_kind_e;

    // dc at bin 0, guard band 101..155, pilots at +-13, +-38, +-63, +-88
    function automatic bin_kind_e bin_kind(input logic [7:0] bin);
        bin_kind_e kind;
        case (bin)
            8'd13, 8'd38, 8'd63, 8'd88:
                kind = BIN_PILOT_POS;
            8'd168, 8'd193, 8'd218, 8'd243:
                kind = BIN_PILOT_NEG;
            default:
            begin
                if (bin == 8'd0 || (bin >= 8'd101 && bin <= 8'd155))
                    kind = BIN_NULL;
                else
                    kind = BIN_DATA;
            end
        endcase
        return kind;
    endfunction

endpackage
